//--- flist.f
+incdir+dv
verilog/ccc_pkg.sv
verilog/ccc_get_responder.sv
verilog/ccc_set_decoder.sv
verilog/ccc_sequencer.sv
verilog/ccc_top.sv
dv/ccc_tb.sv

//--- Bender.yml
package:
  name: ccc_handler

sources:
  - verilog/ccc_pkg.sv
  - verilog/ccc_get_responder.sv
  - verilog/ccc_set_decoder.sv
  - verilog/ccc_sequencer.sv
  - verilog/ccc_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/ccc_tb.sv

//--- dv/ccc_bus_tasks.svh
// Bus model and directed CCC tests, included into the ccc_tb module body
`ifndef CCC_BUS_TASKS_SVH
`define CCC_BUS_TASKS_SVH

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic ccc_pkg::bus_byte_t lcg_byte();
  logic [31:0] r;
  r = lcg_next();
  return r[23:16];
endfunction

task automatic check_value(input string what, input logic [63:0] got,
                           input logic [63:0] exp);
  check_cnt++;
  assert (got === exp) else begin
    err_cnt++;
    $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
  end
endtask

// Done pulse comes 1 to 4 cycles after the request
task automatic answer_delay();
  logic [31:0] r;
  r = lcg_next();
  repeat (1 + r[17:16]) @(negedge clk_i);
endtask

task automatic rx_answer(input logic want_byte, input ccc_pkg::bus_byte_t value);
  while (!(want_byte ? bus_req_o.rx_req_byte : bus_req_o.rx_req_bit)) @(negedge clk_i);
  answer_delay();
  rx_data_i = value;
  rx_done_i = 1'b1;
  @(negedge clk_i);
  rx_done_i = 1'b0;
endtask

task automatic tx_answer(input logic want_byte, output ccc_pkg::bus_byte_t value,
                         output logic od_pp);
  while (!(want_byte ? bus_req_o.tx_req_byte : bus_req_o.tx_req_bit)) @(negedge clk_i);
  answer_delay();
  value     = bus_req_o.tx_value;
  od_pp     = bus_req_o.sel_od_pp;
  tx_done_i = 1'b1;
  @(negedge clk_i);
  tx_done_i = 1'b0;
endtask

// Code handed over by the primary FSM, then its T-bit (odd parity)
task automatic start_ccc(input ccc_pkg::ccc_code_t code);
  ccc_i       = code;
  ccc_valid_i = 1'b1;
  @(negedge clk_i);
  ccc_valid_i = 1'b0;
  rx_answer(1'b0, {~^code, 7'h0});
endtask

task automatic write_byte(input ccc_pkg::bus_byte_t value);
  rx_answer(1'b1, value);
  rx_answer(1'b0, {~^value, 7'h0});
endtask

// Two data bytes meant for another target, clocked in without a DUT request
task automatic push_other_data(input logic [15:0] value);
  rx_done_i = 1'b1;
  for (int unsigned i = 0; i < 2; i++) begin
    rx_data_i = value[8 * (1 - i) +: 8];
    @(negedge clk_i);
    rx_data_i = {~^value[8 * (1 - i) +: 8], 7'h0};
    @(negedge clk_i);
  end
  rx_done_i = 1'b0;
endtask

task automatic send_rstart();
  bus_ev_i.rstart_det = 1'b1;
  @(negedge clk_i);
  bus_ev_i.rstart_det = 1'b0;
endtask

task automatic end_frame();
  bus_ev_i.stop_det = 1'b1;
  @(negedge clk_i);
  bus_ev_i.stop_det = 1'b0;
  @(negedge clk_i);
endtask

// Sr, address byte, then the target's ACK bit
task automatic address_target(input ccc_pkg::i3c_addr_t addr, input logic rnw,
                              output logic ack);
  ccc_pkg::bus_byte_t value;
  logic               od_pp;
  send_rstart();
  rx_answer(1'b1, {addr, rnw});
  tx_answer(1'b0, value, od_pp);
  ack = value[0];
endtask

task automatic read_get(input ccc_pkg::ccc_code_t code, input logic [47:0] payload,
                        input int unsigned len);
  ccc_pkg::bus_byte_t value;
  logic               od_pp;
  logic               ack;
  start_ccc(code);
  address_target(DynAddr, 1'b1, ack);
  check_value("GET ACK", ack, 0);
  for (int unsigned i = 0; i < len; i++) begin
    tx_answer(1'b1, value, od_pp);
    check_value("GET data byte", value, payload[8 * (len - 1 - i) +: 8]);
    check_value("sel_od_pp during data", od_pp, 1);
    tx_answer(1'b0, value, od_pp);
    check_value("GET T-bit", value[0], i != len - 1);
  end
  end_frame();
endtask

task automatic test_bcast_lengths();
  ccc_pkg::bus_byte_t hi;
  ccc_pkg::bus_byte_t lo;
  int unsigned        strobes0;
  int unsigned        done0;
  hi       = lcg_byte();
  lo       = lcg_byte();
  strobes0 = mwl_strobes;
  done0    = done_pulses;
  start_ccc(ccc_pkg::CccBcastSetmwl);
  write_byte(hi);
  write_byte(lo);
  end_frame();
  check_value("mwl", csr_set_o.mwl, {hi, lo});
  check_value("set_mwl strobes", mwl_strobes - strobes0, 1);
  check_value("done pulses", done_pulses - done0, 1);
  hi       = lcg_byte();
  lo       = lcg_byte();
  strobes0 = mrl_strobes;
  start_ccc(ccc_pkg::CccBcastSetmrl);
  write_byte(hi);
  write_byte(lo);
  end_frame();
  check_value("mrl", csr_set_o.mrl, {hi, lo});
  check_value("set_mrl strobes", mrl_strobes - strobes0, 1);
endtask

task automatic test_event_flags();
  ccc_pkg::bus_byte_t ev;
  logic               ack;
  ev = lcg_byte();
  start_ccc(ccc_pkg::CccBcastEnec);
  write_byte(ev);
  end_frame();
  check_value("ENEC flags", {csr_set_o.enec_hj, csr_set_o.enec_crr, csr_set_o.enec_ibi},
              {ev[3], ev[1], ev[0]});
  ev = lcg_byte();
  start_ccc(ccc_pkg::CccDirectDisec);
  address_target(DynAddr, 1'b0, ack);
  check_value("DISEC ACK", ack, 0);
  write_byte(ev);
  end_frame();
  check_value("DISEC flags", {csr_set_o.disec_hj, csr_set_o.disec_crr, csr_set_o.disec_ibi},
              {ev[3], ev[1], ev[0]});
endtask

task automatic test_get_ccc();
  logic [63:0] r;
  r[63:32]         = lcg_next();
  r[31:0]          = lcg_next();
  csr_get_i.pid    = r[47:0];
  csr_get_i.mrl    = r[63:48];
  r[63:32]         = lcg_next();
  r[31:0]          = lcg_next();
  csr_get_i.bcr    = r[7:0];
  csr_get_i.dcr    = r[15:8];
  csr_get_i.status = r[31:16];
  csr_get_i.mwl    = r[47:32];
  read_get(ccc_pkg::CccDirectGetpid, csr_get_i.pid, 6);
  // Third GETMRL byte is the max IBI payload
  read_get(ccc_pkg::CccDirectGetmrl, {csr_get_i.mrl, 8'hFF}, 3);
  read_get(ccc_pkg::CccDirectGetbcr, csr_get_i.bcr, 1);
  read_get(ccc_pkg::CccDirectGetstatus, csr_get_i.status, 2);
endtask

task automatic test_addr_mismatch();
  ccc_pkg::bus_byte_t hi;
  ccc_pkg::bus_byte_t lo;
  logic               ack;
  logic [15:0]        mwl0;
  int unsigned        strobes0;
  mwl0 = csr_set_o.mwl;
  start_ccc(ccc_pkg::CccDirectSetmwl);
  address_target(OtherAddr, 1'b0, ack);
  check_value("ACK for another address", ack, 1);
  push_other_data(~mwl0);
  check_value("mwl after NACK", csr_set_o.mwl, mwl0);
  address_target(DynAddr, 1'b0, ack);
  check_value("ACK after Sr to own address", ack, 0);
  hi = lcg_byte();
  lo = lcg_byte();
  write_byte(hi);
  write_byte(lo);
  end_frame();
  check_value("mwl after Sr to own address", csr_set_o.mwl, {hi, lo});
  mwl0     = csr_set_o.mwl;
  strobes0 = mwl_strobes;
  start_ccc(ccc_pkg::CccDirectSetmwl);
  address_target(ccc_pkg::RsvdAddr, 1'b0, ack);
  check_value("ACK for address 7E", ack, 0);
  // Target only waits for the STOP now
  push_other_data(~mwl0);
  check_value("bus request while waiting for stop", bus_req_o, 0);
  end_frame();
  check_value("mwl after address 7E", csr_set_o.mwl, mwl0);
  check_value("set_mwl strobes after address 7E", mwl_strobes - strobes0, 0);
endtask

task automatic test_setdasa();
  ccc_pkg::bus_byte_t value;
  logic               ack;
  int unsigned        strobes0;
  value    = lcg_byte();
  // Bit 7 set keeps the new address away from the static one
  value[7] = 1'b1;
  value[0] = 1'b0;
  strobes0 = dasa_strobes;
  addr_cfg_i.dyn_valid = 1'b0;
  start_ccc(ccc_pkg::CccDirectSetdasa);
  address_target(StaAddr, 1'b0, ack);
  check_value("SETDASA ACK on static address", ack, 0);
  write_byte(value);
  end_frame();
  check_value("dasa after SETDASA", csr_set_o.dasa, value[7:1]);
  check_value("set_dasa_valid strobes after SETDASA", dasa_strobes - strobes0, 1);
  addr_cfg_i.dyn_valid = 1'b1;
endtask

task automatic test_setaasa_rstdaa();
  int unsigned pulses0;
  int unsigned strobes0;
  strobes0 = dasa_strobes;
  start_ccc(ccc_pkg::CccBcastSetaasa);
  end_frame();
  check_value("dasa after SETAASA", csr_set_o.dasa, StaAddr);
  check_value("set_dasa_valid strobes after SETAASA", dasa_strobes - strobes0, 1);
  pulses0 = rstdaa_pulses;
  start_ccc(ccc_pkg::CccBcastRstdaa);
  end_frame();
  check_value("rstdaa pulses", rstdaa_pulses - pulses0, 1);
endtask

`endif

//--- dv/ccc_tb.sv
// Testbench top for the CCC handler, runs the directed bus tests against ccc_top
module ccc_tb;

  localparam int unsigned        MaxCycles = 3000;
  localparam ccc_pkg::i3c_addr_t StaAddr   = 7'h3A;
  localparam ccc_pkg::i3c_addr_t DynAddr   = 7'h15;
  localparam ccc_pkg::i3c_addr_t OtherAddr = 7'h22;

  logic                clk_i;
  logic                rst_ni;
  ccc_pkg::ccc_code_t  ccc_i;
  logic                ccc_valid_i;
  ccc_pkg::bus_ev_t    bus_ev_i;
  ccc_pkg::bus_byte_t  rx_data_i;
  logic                rx_done_i;
  logic                tx_done_i;
  ccc_pkg::addr_cfg_t  addr_cfg_i;
  ccc_pkg::csr_get_t   csr_get_i;
  ccc_pkg::bus_req_t   bus_req_o;
  logic                done_o;
  ccc_pkg::csr_set_t   csr_set_o;

  logic [31:0] lcg_state     = 32'd88345;
  int unsigned err_cnt       = 0;
  int unsigned check_cnt     = 0;
  int unsigned cycle_cnt     = 0;
  int unsigned mwl_strobes   = 0;
  int unsigned mrl_strobes   = 0;
  int unsigned rstdaa_pulses = 0;
  int unsigned dasa_strobes  = 0;
  int unsigned done_pulses   = 0;

  ccc_top ccc_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ccc_i       (ccc_i),
    .ccc_valid_i (ccc_valid_i),
    .bus_ev_i    (bus_ev_i),
    .rx_data_i   (rx_data_i),
    .rx_done_i   (rx_done_i),
    .tx_done_i   (tx_done_i),
    .addr_cfg_i  (addr_cfg_i),
    .csr_get_i   (csr_get_i),
    .bus_req_o   (bus_req_o),
    .done_o      (done_o),
    .csr_set_o   (csr_set_o)
  );

  `include "ccc_bus_tasks.svh"

  always #20 clk_i = ~clk_i;

  // Strobes and done are single-cycle pulses, counted in the middle of the cycle
  always @(negedge clk_i) begin
    if (csr_set_o.set_mwl) mwl_strobes++;
    if (csr_set_o.set_mrl) mrl_strobes++;
    if (csr_set_o.rstdaa) rstdaa_pulses++;
    if (csr_set_o.set_dasa_valid) dasa_strobes++;
    if (done_o) done_pulses++;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout after %0d cycles, the DUT never finished the tests", cycle_cnt);
      $display("Checks: %0d, errors: %0d, timeout: 1", check_cnt, err_cnt);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    ccc_i       = '0;
    ccc_valid_i = 1'b0;
    bus_ev_i    = '0;
    rx_data_i   = '0;
    rx_done_i   = 1'b0;
    tx_done_i   = 1'b0;
    addr_cfg_i  = {StaAddr, 1'b1, DynAddr, 1'b1};
    csr_get_i   = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("bus request after reset", bus_req_o, 0);
    check_value("done after reset", done_o, 0);
    check_value("CSR outputs after reset", csr_set_o, 0);

    test_bcast_lengths();
    test_event_flags();
    test_get_ccc();
    test_addr_mismatch();
    test_setdasa();
    test_setaasa_rstdaa();

    $display("Checks: %0d, errors: %0d, timeout: 0", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/ccc_top.sv
// Top of the CCC handler, connects the frame sequencer, GET responder and SET decoder
module ccc_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ccc_pkg::ccc_code_t  ccc_i,
  input  logic                ccc_valid_i,
  input  ccc_pkg::bus_ev_t    bus_ev_i,
  input  ccc_pkg::bus_byte_t  rx_data_i,
  input  logic                rx_done_i,
  input  logic                tx_done_i,
  input  ccc_pkg::addr_cfg_t  addr_cfg_i,
  input  ccc_pkg::csr_get_t   csr_get_i,
  output ccc_pkg::bus_req_t   bus_req_o,
  output logic                done_o,
  output ccc_pkg::csr_set_t   csr_set_o
);

  ccc_pkg::ccc_code_t ccc_code;
  logic               data_valid;
  ccc_pkg::bus_byte_t data;
  ccc_pkg::byte_idx_t data_idx;
  logic               cc_tbit_valid;
  logic               get_load;
  logic               get_next;
  ccc_pkg::bus_byte_t get_byte;
  logic               get_last;

  ccc_sequencer ccc_sequencer_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ccc_i           (ccc_i),
    .ccc_valid_i     (ccc_valid_i),
    .bus_ev_i        (bus_ev_i),
    .rx_data_i       (rx_data_i),
    .rx_done_i       (rx_done_i),
    .tx_done_i       (tx_done_i),
    .addr_cfg_i      (addr_cfg_i),
    .get_byte_i      (get_byte),
    .get_last_i      (get_last),
    .bus_req_o       (bus_req_o),
    .done_o          (done_o),
    .ccc_code_o      (ccc_code),
    .data_valid_o    (data_valid),
    .data_o          (data),
    .data_idx_o      (data_idx),
    .cc_tbit_valid_o (cc_tbit_valid),
    .get_load_o      (get_load),
    .get_next_o      (get_next)
  );

  ccc_get_responder ccc_get_responder_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ccc_code_i (ccc_code),
    .csr_get_i  (csr_get_i),
    .get_load_i (get_load),
    .get_next_i (get_next),
    .get_byte_o (get_byte),
    .get_last_o (get_last)
  );

  ccc_set_decoder ccc_set_decoder_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ccc_code_i      (ccc_code),
    .data_valid_i    (data_valid),
    .data_i          (data),
    .data_idx_i      (data_idx),
    .cc_tbit_valid_i (cc_tbit_valid),
    .addr_cfg_i      (addr_cfg_i),
    .csr_set_o       (csr_set_o)
  );

endmodule

//--- verilog/ccc_sequencer.sv
// CCC frame FSM, takes over after the command code and drives the bus request interface
module ccc_sequencer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ccc_pkg::ccc_code_t  ccc_i,
  input  logic                ccc_valid_i,
  input  ccc_pkg::bus_ev_t    bus_ev_i,
  input  ccc_pkg::bus_byte_t  rx_data_i,
  input  logic                rx_done_i,
  input  logic                tx_done_i,
  input  ccc_pkg::addr_cfg_t  addr_cfg_i,
  input  ccc_pkg::bus_byte_t  get_byte_i,
  input  logic                get_last_i,
  output ccc_pkg::bus_req_t   bus_req_o,
  output logic                done_o,
  output ccc_pkg::ccc_code_t  ccc_code_o,
  output logic                data_valid_o,
  output ccc_pkg::bus_byte_t  data_o,
  output ccc_pkg::byte_idx_t  data_idx_o,
  output logic                cc_tbit_valid_o,
  output logic                get_load_o,
  output logic                get_next_o
);

  typedef enum logic [3:0] {
    Idle,
    WaitCcc,
    RxCcTbit,
    RxByte,
    RxDirectAddr,
    TxAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    WaitBusCond,
    WaitStop,
    Done
  } state_e;

  state_e             state_q, state_d;
  ccc_pkg::ccc_code_t ccc_code_q;
  ccc_pkg::i3c_addr_t addr_q;
  logic               rnw_q;
  ccc_pkg::bus_byte_t data_q;
  ccc_pkg::byte_idx_t idx_q;

  logic ccc_accept;
  logic frame_active;
  logic addr_match;
  logic tgt_rsvd;

  assign ccc_accept   = ccc_valid_i && (state_q inside {Idle, WaitCcc});
  assign frame_active = !(state_q inside {Idle, WaitCcc, Done});

  // Dynamic address wins once assigned
  assign addr_match = addr_cfg_i.dyn_valid ? (addr_q == addr_cfg_i.dyn_addr) :
                      (addr_cfg_i.sta_valid && (addr_q == addr_cfg_i.sta_addr));
  assign tgt_rsvd   = (addr_q == ccc_pkg::RsvdAddr);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ccc_code_q <= '0;
      addr_q     <= '0;
      rnw_q      <= 1'b0;
      idx_q      <= '0;
    end else begin
      if (ccc_accept) begin
        ccc_code_q <= ccc_i;
        addr_q     <= '0;
        rnw_q      <= 1'b0;
        idx_q      <= '0;
      end else if (state_q == RxDirectAddr && rx_done_i) begin
        addr_q <= rx_data_i[7:1];
        rnw_q  <= rx_data_i[0];
        idx_q  <= '0;
      end else if (state_q == RxDataTbit && rx_done_i && idx_q != '1) begin
        idx_q <= idx_q + 3'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RxData && rx_done_i) begin
      data_q <= rx_data_i;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:     state_d = ccc_valid_i ? RxCcTbit : WaitCcc;
      WaitCcc:  if (ccc_valid_i) state_d = RxCcTbit;
      RxCcTbit: begin
        if (rx_done_i) state_d = ccc_code_q[7] ? RxByte : RxData;
      end
      RxByte: begin
        // Direct CCCs continue with Sr and an address, a plain byte is not ours
        if (bus_ev_i.rstart_det) state_d = RxDirectAddr;
        else if (rx_done_i) state_d = WaitBusCond;
      end
      RxDirectAddr: if (rx_done_i) state_d = TxAddrAck;
      TxAddrAck: begin
        if (tx_done_i) begin
          if (tgt_rsvd) state_d = WaitStop;
          else if (addr_match) state_d = rnw_q ? TxData : RxData;
          else state_d = WaitBusCond;
        end
      end
      RxData: begin
        if (bus_ev_i.rstart_det) state_d = RxDirectAddr;
        else if (rx_done_i) state_d = RxDataTbit;
      end
      RxDataTbit: if (rx_done_i) state_d = RxData;
      TxData: begin
        if (bus_ev_i.rstart_det) state_d = RxDirectAddr;
        else if (tx_done_i) state_d = TxDataTbit;
      end
      TxDataTbit: begin
        if (tx_done_i) state_d = get_last_i ? WaitBusCond : TxData;
      end
      WaitBusCond: if (bus_ev_i.rstart_det) state_d = RxDirectAddr;
      WaitStop:    state_d = WaitStop;
      Done:        state_d = Idle;
      default:     state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (frame_active && (bus_ev_i.stop_det || bus_ev_i.start_det)) begin
      // A START here means the STOP was missed
      state_q <= Done;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    bus_req_o = '0;
    unique case (state_q)
      RxCcTbit, RxDataTbit: bus_req_o.rx_req_bit = 1'b1;
      RxByte, RxData:       bus_req_o.rx_req_byte = !bus_ev_i.rstart_det;
      RxDirectAddr:         bus_req_o.rx_req_byte = 1'b1;
      TxAddrAck: begin
        bus_req_o.tx_req_bit = 1'b1;
        bus_req_o.tx_value   = {7'b0, !(addr_match || tgt_rsvd)};
      end
      TxData: begin
        bus_req_o.tx_req_byte = 1'b1;
        bus_req_o.tx_value    = get_byte_i;
        bus_req_o.sel_od_pp   = 1'b1;
      end
      TxDataTbit: begin
        // T-bit low ends the read
        bus_req_o.tx_req_bit = 1'b1;
        bus_req_o.tx_value   = {7'b0, !get_last_i};
        bus_req_o.sel_od_pp  = 1'b1;
      end
      default: bus_req_o = '0;
    endcase
  end

  assign done_o          = (state_q == Done);
  assign ccc_code_o      = ccc_code_q;
  assign data_o          = data_q;
  assign data_idx_o      = idx_q;
  assign cc_tbit_valid_o = (state_q == RxCcTbit) && rx_done_i;
  assign data_valid_o    = (state_q == RxDataTbit) && rx_done_i && !tgt_rsvd;
  assign get_load_o      = (state_q == TxAddrAck) && tx_done_i && addr_match && rnw_q &&
                           !tgt_rsvd;
  assign get_next_o      = (state_q == TxDataTbit) && tx_done_i;

endmodule

//--- verilog/ccc_set_decoder.sv
// Decodes received CCC data bytes and no-data broadcasts into CSR updates and strobes
module ccc_set_decoder (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ccc_pkg::ccc_code_t  ccc_code_i,
  input  logic                data_valid_i,
  input  ccc_pkg::bus_byte_t  data_i,
  input  ccc_pkg::byte_idx_t  data_idx_i,
  input  logic                cc_tbit_valid_i,
  input  ccc_pkg::addr_cfg_t  addr_cfg_i,
  output ccc_pkg::csr_set_t   csr_set_o
);

  logic is_setmwl;
  logic is_setmrl;
  logic is_enec;
  logic is_disec;
  logic is_setdasa;
  logic is_setaasa;
  logic is_rstdaa;
  logic byte0;
  logic byte1;
  logic [2:0] ev_flags;

  ccc_pkg::bus_byte_t hi_q;

  // Broadcast and direct forms behave the same here
  assign is_setmwl  = ccc_code_i inside {ccc_pkg::CccBcastSetmwl, ccc_pkg::CccDirectSetmwl};
  assign is_setmrl  = ccc_code_i inside {ccc_pkg::CccBcastSetmrl, ccc_pkg::CccDirectSetmrl};
  assign is_enec    = ccc_code_i inside {ccc_pkg::CccBcastEnec, ccc_pkg::CccDirectEnec};
  assign is_disec   = ccc_code_i inside {ccc_pkg::CccBcastDisec, ccc_pkg::CccDirectDisec};
  assign is_setdasa = (ccc_code_i == ccc_pkg::CccDirectSetdasa);
  assign is_setaasa = (ccc_code_i == ccc_pkg::CccBcastSetaasa);
  assign is_rstdaa  = (ccc_code_i == ccc_pkg::CccBcastRstdaa);

  assign byte0 = data_valid_i && (data_idx_i == 3'd0);
  assign byte1 = data_valid_i && (data_idx_i == 3'd1);

  // Ordered as {hj, crr, ibi}
  assign ev_flags = {data_i[ccc_pkg::EvHjBit], data_i[ccc_pkg::EvCrrBit],
                     data_i[ccc_pkg::EvIbiBit]};

  // High byte of MWL/MRL waits for the low byte
  always_ff @(posedge clk_i) begin
    if (byte0) begin
      hi_q <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_set_o <= '0;
    end else begin
      csr_set_o.set_mwl        <= byte1 && is_setmwl;
      csr_set_o.set_mrl        <= byte1 && is_setmrl;
      csr_set_o.rstdaa         <= cc_tbit_valid_i && is_rstdaa;
      csr_set_o.set_dasa_valid <= (byte0 && is_setdasa) || (cc_tbit_valid_i && is_setaasa);

      if (byte1 && is_setmwl) begin
        csr_set_o.mwl <= {hi_q, data_i};
      end
      if (byte1 && is_setmrl) begin
        csr_set_o.mrl <= {hi_q, data_i};
      end
      if (byte0 && is_enec) begin
        {csr_set_o.enec_hj, csr_set_o.enec_crr, csr_set_o.enec_ibi} <= ev_flags;
      end
      if (byte0 && is_disec) begin
        {csr_set_o.disec_hj, csr_set_o.disec_crr, csr_set_o.disec_ibi} <= ev_flags;
      end

      // SETAASA reuses the SETDASA path with the static address
      if (byte0 && is_setdasa) begin
        csr_set_o.dasa <= data_i[7:1];
      end else if (cc_tbit_valid_i && is_setaasa) begin
        csr_set_o.dasa <= addr_cfg_i.sta_addr;
      end
    end
  end

endmodule

//--- verilog/ccc_get_responder.sv
// Supplies the read bytes of direct GET CCCs, most significant byte first
module ccc_get_responder (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ccc_pkg::ccc_code_t  ccc_code_i,
  input  ccc_pkg::csr_get_t   csr_get_i,
  input  logic                get_load_i,
  input  logic                get_next_i,
  output ccc_pkg::bus_byte_t  get_byte_o,
  output logic                get_last_o
);

  ccc_pkg::byte_idx_t len;
  ccc_pkg::byte_idx_t remain_q;
  logic [47:0]        payload;

  // Payload is right aligned, len bytes long
  always_comb begin
    len     = '0;
    payload = '0;
    case (ccc_code_i)
      ccc_pkg::CccDirectGetbcr: begin
        len     = 3'd1;
        payload = {40'h0, csr_get_i.bcr};
      end
      ccc_pkg::CccDirectGetdcr: begin
        len     = 3'd1;
        payload = {40'h0, csr_get_i.dcr};
      end
      ccc_pkg::CccDirectGetstatus: begin
        len     = 3'd2;
        payload = {32'h0, csr_get_i.status};
      end
      ccc_pkg::CccDirectGetmwl: begin
        len     = 3'd2;
        payload = {32'h0, csr_get_i.mwl};
      end
      ccc_pkg::CccDirectGetmrl: begin
        len     = 3'd3;
        payload = {24'h0, csr_get_i.mrl, ccc_pkg::MaxIbiPayload};
      end
      ccc_pkg::CccDirectGetpid: begin
        len     = 3'd6;
        payload = csr_get_i.pid;
      end
      default: begin
        len     = '0;
        payload = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remain_q <= '0;
    end else if (get_load_i) begin
      remain_q <= len;
    end else if (get_next_i && remain_q != '0) begin
      remain_q <= remain_q - 3'd1;
    end
  end

  // Unknown GET sends one zero byte
  assign get_byte_o = (remain_q == '0) ? '0 : payload[{remain_q - 3'd1, 3'b000} +: 8];
  assign get_last_o = (remain_q < 3'd2);

endmodule

//--- verilog/ccc_pkg.sv
// Shared CCC codes, widths and bus/CSR structs for the I3C target CCC handler
package ccc_pkg;

  typedef logic [7:0] ccc_code_t;
  typedef logic [6:0] i3c_addr_t;
  typedef logic [7:0] bus_byte_t;
  typedef logic [2:0] byte_idx_t;

  // Broadcast CCCs
  localparam ccc_code_t CccBcastEnec    = 8'h00;
  localparam ccc_code_t CccBcastDisec   = 8'h01;
  localparam ccc_code_t CccBcastRstdaa  = 8'h06;
  localparam ccc_code_t CccBcastSetmwl  = 8'h09;
  localparam ccc_code_t CccBcastSetmrl  = 8'h0A;
  localparam ccc_code_t CccBcastSetaasa = 8'h29;

  // Direct CCCs, bit 7 set
  localparam ccc_code_t CccDirectEnec      = 8'h80;
  localparam ccc_code_t CccDirectDisec     = 8'h81;
  localparam ccc_code_t CccDirectSetdasa   = 8'h87;
  localparam ccc_code_t CccDirectSetmwl    = 8'h89;
  localparam ccc_code_t CccDirectSetmrl    = 8'h8A;
  localparam ccc_code_t CccDirectGetmwl    = 8'h8B;
  localparam ccc_code_t CccDirectGetmrl    = 8'h8C;
  localparam ccc_code_t CccDirectGetpid    = 8'h8D;
  localparam ccc_code_t CccDirectGetbcr    = 8'h8E;
  localparam ccc_code_t CccDirectGetdcr    = 8'h8F;
  localparam ccc_code_t CccDirectGetstatus = 8'h90;

  localparam i3c_addr_t RsvdAddr      = 7'h7E;
  // Max IBI payload byte of GETMRL
  localparam bus_byte_t MaxIbiPayload = 8'hFF;

  // Flag positions in the ENEC/DISEC byte
  localparam int unsigned EvIbiBit = 0;
  localparam int unsigned EvCrrBit = 1;
  localparam int unsigned EvHjBit  = 3;

  typedef struct packed {
    logic      rx_req_bit;
    logic      rx_req_byte;
    logic      tx_req_bit;
    logic      tx_req_byte;
    bus_byte_t tx_value;
    logic      sel_od_pp;
  } bus_req_t;

  typedef struct packed {
    logic start_det;
    logic rstart_det;
    logic stop_det;
  } bus_ev_t;

  typedef struct packed {
    i3c_addr_t sta_addr;
    logic      sta_valid;
    i3c_addr_t dyn_addr;
    logic      dyn_valid;
  } addr_cfg_t;

  typedef struct packed {
    logic [15:0] mwl;
    logic [15:0] mrl;
    logic [47:0] pid;
    logic [7:0]  bcr;
    logic [7:0]  dcr;
    logic [15:0] status;
  } csr_get_t;

  typedef struct packed {
    logic        set_mwl;
    logic [15:0] mwl;
    logic        set_mrl;
    logic [15:0] mrl;
    logic        enec_ibi;
    logic        enec_crr;
    logic        enec_hj;
    logic        disec_ibi;
    logic        disec_crr;
    logic        disec_hj;
    logic        rstdaa;
    logic        set_dasa_valid;
    i3c_addr_t   dasa;
  } csr_set_t;

endpackage
